//--- src.f
src/sram_test_pkg.sv
src/addr_iter.sv
src/pattern_gen.sv
src/sram_ctrl.sv
src/sram_tester.sv
src/sram_test_top.sv
verif/sram_model.sv
verif/tb_sram_test.sv

//--- run.sh
#!/bin/bash
# Build and run the SRAM self-test simulation with Verilator

ROOT_DIR="$(cd "$(dirname "$0")" && pwd)"
cd "$ROOT_DIR" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_sram_test \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" 2>&1 | tee "$LOG_FILE"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- verif/tb_sram_test.sv
`timescale 1ns/1ns

module tb_sram_test;

  localparam int SEED        = 12655;
  localparam int NUM_RUNS    = 6;
  localparam int RUN_LIMIT   = 4 * 640 + 64;
  localparam int WATCHDOG_NS = 4 * 640 * NUM_RUNS * 40 + 40000;

  logic clk;
  logic reset;
  logic start;
  logic fault_en;
  logic [3:0] fault_bit;

  sram_test_pkg::addr_t          fault_addr;
  sram_test_pkg::data_t          data_in;
  sram_test_pkg::sram_pins_t     pins;
  sram_test_pkg::tester_status_t status;

  // Predicted outcome of the current run
  logic                 pred_pass;
  int                   pred_pattern;
  int                   pred_words;
  sram_test_pkg::addr_t pred_fail_addr;
  sram_test_pkg::data_t pred_last_read;
  sram_test_pkg::data_t pred_last_expected;

  int tests_run;
  int tests_failed;
  int checks;
  int errors;

  sram_test_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .data_in (data_in),
    .pins    (pins),
    .status  (status)
  );

  sram_model u_sram (
    .addr       (pins.addr),
    .data_out   (pins.data_out),
    .ce_n       (pins.ce_n),
    .we_n       (pins.we_n),
    .oe_n       (pins.oe_n),
    .data_in    (data_in),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Data word the tester should use for a pattern and address
  function automatic sram_test_pkg::data_t pattern_word(input int kind_index, input int a);
    sram_test_pkg::data_t word;
    case (kind_index)
      0:       word = 16'h0000;
      1:       word = 16'hFFFF;
      2:       word = 16'h5555;
      3:       word = 16'hAAAA;
      default: word = sram_test_pkg::data_t'(a % 64);
    endcase
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // Walk the patterns in order and find the first read that differs
  task automatic predict_run(input logic fault_on, input sram_test_pkg::addr_t f_addr,
                             input logic [3:0] f_bit);
    sram_test_pkg::data_t ref_mem [0:63];
    sram_test_pkg::data_t word;
    logic stop;
    int k;
    int a;
    stop = 1'b0;
    pred_pass = 1'b1;
    pred_words = 0;
    for (k = 0; k < 5 && !stop; k++) begin
      for (a = 0; a < 64; a++) begin
        ref_mem[a] = pattern_word(k, a);
      end
      pred_words += 64;
      for (a = 0; a < 64 && !stop; a++) begin
        word = ref_mem[a];
        if (fault_on && a == int'(f_addr)) begin
          word[f_bit] = 1'b1;
        end
        pred_pattern = k;
        pred_last_read = word;
        pred_last_expected = pattern_word(k, a);
        if (word != pred_last_expected) begin
          pred_pass = 1'b0;
          pred_fail_addr = sram_test_pkg::addr_t'(a);
          stop = 1'b1;
        end
      end
    end
  endtask

  task automatic pulse_start;
    @(posedge clk);
    #5;
    start = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
  endtask

  task automatic run_once(input string name, input logic use_fault);
    int errs_before;
    int cycles;
    int write_cycles;
    int word_index;
    int gap;
    errs_before = errors;
    cycles = 0;
    write_cycles = 0;
    @(posedge clk);
    #5;
    fault_en = use_fault;
    fault_addr = sram_test_pkg::addr_t'($urandom % 64);
    fault_bit = 4'($urandom % 16);
    predict_run(fault_en, fault_addr, fault_bit);
    gap = int'($urandom % 8) + 1;
    repeat (gap) @(posedge clk);
    pulse_start();
    @(negedge clk);
    check_value("status.done", 32'(status.done), 32'd0);
    while (!status.done && cycles < RUN_LIMIT) begin
      if (!pins.we_n) begin
        // Writes arrive in pattern order at one word per two strobe cycles
        word_index = write_cycles / 2;
        write_cycles++;
        check_value("pins.addr", 32'(pins.addr), word_index % 64);
        check_value("status.pattern", 32'(status.pattern), word_index / 64);
        check_value("pins.data_out", 32'(pins.data_out),
                    32'(pattern_word(word_index / 64, word_index % 64)));
        check_value("pins.data_oe", 32'(pins.data_oe), 32'd1);
      end
      @(negedge clk);
      cycles++;
    end
    if (!status.done) begin
      errors++;
      $display("Run %s did not finish within %0d cycles", name, RUN_LIMIT);
    end else begin
      check_value("status.pass", 32'(status.pass), 32'(pred_pass));
      check_value("status.pattern", 32'(status.pattern), pred_pattern);
      check_value("status.last_read", 32'(status.last_read), 32'(pred_last_read));
      check_value("status.last_expected", 32'(status.last_expected),
                  32'(pred_last_expected));
      if (!pred_pass) begin
        check_value("status.fail_addr", 32'(status.fail_addr), 32'(pred_fail_addr));
      end
      // Two cycles of we_n low per word written
      check_value("write cycles", write_cycles, pred_words * 2);
    end
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("Test %s finished with %0d mismatches", name, errors - errs_before);
  endtask

  initial begin
    int errs_before;
    int n;
    void'($urandom(SEED));
    tests_run = 0;
    tests_failed = 0;
    checks = 0;
    errors = 0;
    reset = 1'b1;
    start = 1'b0;
    fault_en = 1'b0;
    fault_addr = '0;
    fault_bit = '0;
    repeat (4) @(posedge clk);
    #5;
    reset = 1'b0;

    errs_before = errors;
    @(negedge clk);
    check_value("pins.ce_n", 32'(pins.ce_n), 32'd1);
    check_value("pins.we_n", 32'(pins.we_n), 32'd1);
    check_value("pins.oe_n", 32'(pins.oe_n), 32'd1);
    check_value("pins.data_oe", 32'(pins.data_oe), 32'd0);
    check_value("status.done", 32'(status.done), 32'd0);
    check_value("status.pass", 32'(status.pass), 32'd1);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("Test reset_state finished with %0d mismatches", errors - errs_before);

    run_once("clean_run", 1'b0);
    for (n = 1; n <= NUM_RUNS - 2; n++) begin
      run_once($sformatf("fault_run_%0d", n), 1'b1);
    end
    // Back to a clean part after the halted runs
    run_once("restart_clean", 1'b0);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verif/sram_model.sv
`timescale 1ns/1ns

module sram_model (
  input  sram_test_pkg::addr_t  addr,
  input  sram_test_pkg::data_t  data_out,
  input  logic                  ce_n,
  input  logic                  we_n,
  input  logic                  oe_n,
  output sram_test_pkg::data_t  data_in,
  input  logic                  fault_en,
  input  sram_test_pkg::addr_t  fault_addr,
  input  logic [3:0]            fault_bit
);

  sram_test_pkg::data_t mem [0:63];
  sram_test_pkg::data_t fault_mask;
  sram_test_pkg::data_t read_word;
  logic                 ce_n_d;

  // Power-up contents, scrambled over the whole address
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 16'(i * 40503) ^ 16'hC3A5;
    end
  end

  // Chip select as seen just before the strobe edge
  assign #1 ce_n_d = ce_n;

  // Write completes when we_n rises while the chip is selected
  always @(posedge we_n) begin
    if (ce_n_d == 1'b0) begin
      mem[addr] = data_out;
    end
  end

  // Stuck-at-one cell
  assign fault_mask = (fault_en && addr == fault_addr) ?
                      (sram_test_pkg::data_t'(1) << fault_bit) : '0;

  assign read_word = mem[addr] | fault_mask;

  assign data_in = (!ce_n && !oe_n) ? read_word : '0;

endmodule

//--- src/sram_test_top.sv
`timescale 1ns/1ns

module sram_test_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  sram_test_pkg::data_t            data_in,
  output sram_test_pkg::sram_pins_t       pins,
  output sram_test_pkg::tester_status_t   status
);

  sram_test_pkg::addr_t         addr;
  logic                         addr_last;
  logic                         addr_clear;
  logic                         addr_step;
  sram_test_pkg::pattern_kind_t kind;
  logic                         final_kind;
  sram_test_pkg::data_t         expected;
  logic                         pat_clear;
  logic                         pat_advance;
  logic                         req_valid;
  sram_test_pkg::sram_req_t     req;
  logic                         busy;
  logic                         ack;
  sram_test_pkg::data_t         rdata;

  sram_tester u_tester (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .addr        (addr),
    .addr_last   (addr_last),
    .addr_clear  (addr_clear),
    .addr_step   (addr_step),
    .kind        (kind),
    .final_kind  (final_kind),
    .expected    (expected),
    .pat_clear   (pat_clear),
    .pat_advance (pat_advance),
    .req_valid   (req_valid),
    .req         (req),
    .busy        (busy),
    .ack         (ack),
    .rdata       (rdata),
    .status      (status)
  );

  addr_iter u_addr (
    .clk   (clk),
    .reset (reset),
    .clear (addr_clear),
    .step  (addr_step),
    .addr  (addr),
    .last  (addr_last)
  );

  pattern_gen u_pattern (
    .clk        (clk),
    .reset      (reset),
    .clear      (pat_clear),
    .advance    (pat_advance),
    .addr       (addr),
    .kind       (kind),
    .final_kind (final_kind),
    .expected   (expected)
  );

  sram_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .ack       (ack),
    .rdata     (rdata),
    .pins      (pins),
    .data_in   (data_in)
  );

endmodule

//--- src/sram_tester.sv
`timescale 1ns/1ns

module sram_tester (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  sram_test_pkg::addr_t            addr,
  input  logic                            addr_last,
  output logic                            addr_clear,
  output logic                            addr_step,
  input  sram_test_pkg::pattern_kind_t    kind,
  input  logic                            final_kind,
  input  sram_test_pkg::data_t            expected,
  output logic                            pat_clear,
  output logic                            pat_advance,
  output logic                            req_valid,
  output sram_test_pkg::sram_req_t        req,
  input  logic                            busy,
  input  logic                            ack,
  input  sram_test_pkg::data_t            rdata,
  output sram_test_pkg::tester_status_t   status
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE_ISSUE,
    WRITE_WAIT,
    READ_ISSUE,
    READ_WAIT,
    FINISHED,
    HALTED
  } state_t;

  state_t state;
  state_t next_state;

  logic done_q;
  logic pass_q;
  logic mismatch;

  sram_test_pkg::addr_t fail_addr_q;
  sram_test_pkg::data_t last_read_q;
  sram_test_pkg::data_t last_expected_q;

  assign mismatch = (rdata != expected);

  always_comb begin
    next_state  = state;
    addr_clear  = 1'b0;
    addr_step   = 1'b0;
    pat_clear   = 1'b0;
    pat_advance = 1'b0;
    req_valid   = 1'b0;

    case (state)
      IDLE, FINISHED, HALTED: begin
        if (start) begin
          addr_clear = 1'b1;
          pat_clear  = 1'b1;
          next_state = WRITE_ISSUE;
        end
      end

      WRITE_ISSUE: begin
        if (!busy) begin
          req_valid  = 1'b1;
          next_state = WRITE_WAIT;
        end
      end

      WRITE_WAIT: begin
        if (ack) begin
          if (addr_last) begin
            // Whole array written, go back and read it
            addr_clear = 1'b1;
            next_state = READ_ISSUE;
          end else begin
            addr_step  = 1'b1;
            next_state = WRITE_ISSUE;
          end
        end
      end

      READ_ISSUE: begin
        if (!busy) begin
          req_valid  = 1'b1;
          next_state = READ_WAIT;
        end
      end

      READ_WAIT: begin
        if (ack) begin
          if (mismatch) begin
            next_state = HALTED;
          end else if (addr_last) begin
            if (final_kind) begin
              next_state = FINISHED;
            end else begin
              pat_advance = 1'b1;
              addr_clear  = 1'b1;
              next_state  = WRITE_ISSUE;
            end
          end else begin
            addr_step  = 1'b1;
            next_state = READ_ISSUE;
          end
        end
      end

      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= IDLE;
      done_q <= 1'b0;
      pass_q <= 1'b1;
    end else begin
      state <= next_state;
      if (pat_clear) begin
        done_q <= 1'b0;
        pass_q <= 1'b1;
      end else if (state == READ_WAIT && ack) begin
        if (mismatch) begin
          done_q <= 1'b1;
          pass_q <= 1'b0;
        end else if (addr_last && final_kind) begin
          done_q <= 1'b1;
        end
      end
    end
  end

  // Result words of the most recent read
  always_ff @(posedge clk) begin
    if (state == READ_WAIT && ack) begin
      last_read_q     <= rdata;
      last_expected_q <= expected;
      if (mismatch) begin
        fail_addr_q <= addr;
      end
    end
  end

  assign req = '{
    write: (state == WRITE_ISSUE),
    addr:  addr,
    wdata: expected
  };

  assign status = '{
    done:          done_q,
    pass:          pass_q,
    pattern:       kind,
    fail_addr:     fail_addr_q,
    last_read:     last_read_q,
    last_expected: last_expected_q
  };

endmodule

//--- src/sram_ctrl.sv
`timescale 1ns/1ns

module sram_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_valid,
  input  sram_test_pkg::sram_req_t    req,
  output logic                        busy,
  output logic                        ack,
  output sram_test_pkg::data_t        rdata,
  output sram_test_pkg::sram_pins_t   pins,
  input  sram_test_pkg::data_t        data_in
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS1,
    ACCESS2,
    FINISH
  } state_t;

  state_t state;

  logic ce_n_q;
  logic we_n_q;
  logic oe_n_q;
  logic data_oe_q;

  sram_test_pkg::addr_t addr_q;
  sram_test_pkg::data_t data_out_q;
  sram_test_pkg::data_t rdata_q;

  // Strobes come straight from flops so the pins never glitch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      ce_n_q    <= 1'b1;
      we_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
      data_oe_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req_valid) begin
            state     <= ACCESS1;
            ce_n_q    <= 1'b0;
            we_n_q    <= ~req.write;
            oe_n_q    <= req.write;
            data_oe_q <= req.write;
          end
        end
        ACCESS1: begin
          state <= ACCESS2;
        end
        ACCESS2: begin
          // Release the bus after the second access cycle
          state     <= FINISH;
          ce_n_q    <= 1'b1;
          we_n_q    <= 1'b1;
          oe_n_q    <= 1'b1;
          data_oe_q <= 1'b0;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && req_valid) begin
      addr_q     <= req.addr;
      data_out_q <= req.wdata;
    end
    // Sample read data at the end of the access
    if (state == ACCESS2 && !oe_n_q) begin
      rdata_q <= data_in;
    end
  end

  assign busy  = (state != IDLE);
  assign ack   = (state == FINISH);
  assign rdata = rdata_q;

  assign pins = '{
    addr:     addr_q,
    data_out: data_out_q,
    data_oe:  data_oe_q,
    ce_n:     ce_n_q,
    we_n:     we_n_q,
    oe_n:     oe_n_q
  };

endmodule

//--- src/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          clear,
  input  logic                          advance,
  input  sram_test_pkg::addr_t          addr,
  output sram_test_pkg::pattern_kind_t  kind,
  output logic                          final_kind,
  output sram_test_pkg::data_t          expected
);

  sram_test_pkg::pattern_kind_t next_kind;

  // Successor in run order, the last pattern stays put
  always_comb begin
    case (kind)
      sram_test_pkg::PAT_ZEROS:       next_kind = sram_test_pkg::PAT_ONES;
      sram_test_pkg::PAT_ONES:        next_kind = sram_test_pkg::PAT_CHECKER;
      sram_test_pkg::PAT_CHECKER:     next_kind = sram_test_pkg::PAT_INV_CHECKER;
      sram_test_pkg::PAT_INV_CHECKER: next_kind = sram_test_pkg::PAT_ADDR;
      default:                        next_kind = sram_test_pkg::PAT_ADDR;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      kind <= sram_test_pkg::PAT_ZEROS;
    end else if (clear) begin
      kind <= sram_test_pkg::PAT_ZEROS;
    end else if (advance && !final_kind) begin
      kind <= next_kind;
    end
  end

  assign final_kind = (kind == sram_test_pkg::PAT_ADDR);

  // Expected word for the current address
  always_comb begin
    case (kind)
      sram_test_pkg::PAT_ZEROS: begin
        expected = '0;
      end
      sram_test_pkg::PAT_ONES: begin
        expected = '1;
      end
      sram_test_pkg::PAT_CHECKER: begin
        expected = {(sram_test_pkg::DATA_BITS / 2){2'b01}};
      end
      sram_test_pkg::PAT_INV_CHECKER: begin
        expected = {(sram_test_pkg::DATA_BITS / 2){2'b10}};
      end
      sram_test_pkg::PAT_ADDR: begin
        // Address zero-extended into the data word
        expected = sram_test_pkg::data_t'(addr);
      end
      default: begin
        expected = '0;
      end
    endcase
  end

endmodule

//--- src/addr_iter.sv
`timescale 1ns/1ns

module addr_iter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  step,
  output sram_test_pkg::addr_t  addr,
  output logic                  last
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr <= '0;
    end else if (clear) begin
      addr <= '0;
    end else if (step) begin
      // Wrap back to zero after the top address
      if (last) begin
        addr <= '0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  // Tells the tester this is the final word of a pass
  assign last = (addr == sram_test_pkg::LAST_ADDR);

endmodule

//--- src/sram_test_pkg.sv
package sram_test_pkg;

  localparam int ADDR_BITS = 6;
  localparam int DATA_BITS = 16;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] data_t;

  // Highest word address of the part under test
  localparam addr_t LAST_ADDR = addr_t'((1 << ADDR_BITS) - 1);

  // Listed in run order
  typedef enum logic [2:0] {
    PAT_ZEROS       = 3'd0,
    PAT_ONES        = 3'd1,
    PAT_CHECKER     = 3'd2,
    PAT_INV_CHECKER = 3'd3,
    PAT_ADDR        = 3'd4
  } pattern_kind_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } sram_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data_out;
    logic  data_oe;
    logic  ce_n;
    logic  we_n;
    logic  oe_n;
  } sram_pins_t;

  typedef struct packed {
    logic          done;
    logic          pass;
    pattern_kind_t pattern;
    addr_t         fail_addr;
    data_t         last_read;
    data_t         last_expected;
  } tester_status_t;

endpackage
